/* src/issue_stage.sv */
`timescale 1ns/1ns

module issue_stage (
	input  logic          clk,
	input  logic          rst,
	input  logic          issue_req,
	input  logic          head_valid,
	input  phx_pkg::tid_t head_tid,
	output logic          pop,
	output logic          credit_ret,
	output logic          issue_valid,
	output phx_pkg::tid_t issue_tid
);

	// ==================================================
	// Pop and credit return
	// ==================================================

	// The pipeline asks for a thread and takes one only if the queue has one
	assign pop = issue_req && head_valid;

	// Each popped entry frees one FIFO slot for the arbiter
	// The return goes out in the same cycle as the pop
	assign credit_ret = pop;

	// ==================================================
	// Issue register
	// ==================================================

	// Valid follows the pop by one cycle and drops when there is no pop
	always_ff @(posedge clk) begin
		if (rst) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= pop;
		end
	end

	// The id is captured only on a pop and holds otherwise
	always_ff @(posedge clk) begin
		if (pop) begin
			issue_tid <= head_tid;
		end
	end

	// The id held in issue_tid came from a valid head
	a_issue_known: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> !$isunknown(issue_tid))
		else $error("issue_stage: issued id unknown");

endmodule

/* src/phx_pkg.sv */
`include "phx_settings.svh"

package phx_pkg;

	// ==================================================
	// Thread queue types
	// ==================================================

	// Identifies one hardware thread
	typedef logic [`PHX_TID_W-1:0] tid_t;

	// One bit per thread, used for wake pulses and pending bits
	typedef logic [`PHX_NTHREADS-1:0] tmask_t;

	// Number of entries held in the thread-id FIFO
	typedef logic [`PHX_TQ_AW-1:0] tq_cnt_t;

	// Free FIFO entries as seen by the arbiter
	// Wide enough to hold the full capacity
	typedef logic [`PHX_TQ_AW-1:0] credit_t;

endpackage

/* src/phx_settings.svh */
`ifndef PHX_SETTINGS_SVH
`define PHX_SETTINGS_SVH

// ==================================================
// Thread ready queue sizing
// ==================================================

// Number of hardware threads in the core
`define PHX_NTHREADS 8

// Bits needed to name one thread
`define PHX_TID_W 3

// Log2 of the number of FIFO slots
`define PHX_TQ_AW 3

// One slot always stays empty so that full and empty look different
`define PHX_TQ_CAP ((1 << `PHX_TQ_AW) - 1)

`endif

/* src/thread_fifo.sv */
`timescale 1ns/1ns
`include "phx_settings.svh"

module thread_fifo (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  phx_pkg::tid_t    push_tid,
	input  logic             pop,
	output phx_pkg::tid_t    head_tid,
	output phx_pkg::tq_cnt_t tq_count,
	output logic             full,
	output logic             head_valid
);
	import phx_pkg::*;

	localparam int SLOTS = 1 << `PHX_TQ_AW;

	// Storage for queued thread ids
	tid_t mem [0:SLOTS-1];

	// Pointers are exactly as wide as the slot index and wrap on their own
	tq_cnt_t wr_ptr;
	tq_cnt_t rd_ptr;

	// ==================================================
	// Pointer update
	// ==================================================

	// Push and pop are independent, so a cycle with both moves both pointers
	// and the occupancy stays the same
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// The entry lands in the slot the write pointer names at the push edge
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_tid;
		end
	end

	// ==================================================
	// Status and head
	// ==================================================

	// Modular difference of the pointers gives the occupancy directly
	assign tq_count = wr_ptr - rd_ptr;

	// Full at slots minus one, keeping one slot free
	assign full = (tq_count == tq_cnt_t'(`PHX_TQ_CAP));

	assign head_valid = (tq_count != '0);

	// The head is read straight from memory, so a pop takes it this cycle
	assign head_tid = mem[rd_ptr];

	// The arbiter's credit count must keep it from writing a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		!(push && full))
		else $error("thread_fifo: push while full");

	// The issue stage must only pop while an entry is present
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		!(pop && !head_valid))
		else $error("thread_fifo: pop while empty");

endmodule

/* src/thread_queue_top.sv */
`timescale 1ns/1ns

module thread_queue_top (
	input  logic             clk,
	input  logic             rst,
	input  phx_pkg::tmask_t  wake,
	input  logic             issue_req,
	output logic             issue_valid,
	output phx_pkg::tid_t    issue_tid,
	output phx_pkg::tq_cnt_t tq_count
);
	import phx_pkg::*;

	// Arbiter to FIFO
	logic push;
	tid_t push_tid;

	// FIFO to issue stage
	tid_t head_tid;
	logic head_valid;

	// Issue stage back to FIFO and arbiter
	logic pop;
	logic credit_ret;

	// ==================================================
	// Wake arbiter, thread-id FIFO, issue stage
	// ==================================================

	wake_arbiter arb0 (
		.clk        (clk),
		.rst        (rst),
		.wake       (wake),
		.credit_ret (credit_ret),
		.push       (push),
		.push_tid   (push_tid)
	);

	// Credits already keep the arbiter from filling past capacity, so full is unused here
	thread_fifo fifo0 (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_tid   (push_tid),
		.pop        (pop),
		.head_tid   (head_tid),
		.tq_count   (tq_count),
		.full       (),
		.head_valid (head_valid)
	);

	issue_stage iss0 (
		.clk         (clk),
		.rst         (rst),
		.issue_req   (issue_req),
		.head_valid  (head_valid),
		.head_tid    (head_tid),
		.pop         (pop),
		.credit_ret  (credit_ret),
		.issue_valid (issue_valid),
		.issue_tid   (issue_tid)
	);

endmodule

/* src/wake_arbiter.sv */
`timescale 1ns/1ns
`include "phx_settings.svh"

module wake_arbiter (
	input  logic            clk,
	input  logic            rst,
	input  phx_pkg::tmask_t wake,
	input  logic            credit_ret,
	output logic            push,
	output phx_pkg::tid_t   push_tid
);
	import phx_pkg::*;

	// Per-cycle mode of the arbiter
	typedef enum logic {
		idle,
		granting
	} grant_state_t;

	// Threads that woke and are not yet queued
	tmask_t pending;
	// One-hot mask of the thread granted this cycle
	tmask_t grant_mask;
	// Thread that has top priority in the next search
	tid_t rr_ptr;
	// Free FIFO entries
	credit_t credits;
	// Some pending bit was found by the search
	logic grant_found;
	grant_state_t grant_state;

	// ==================================================
	// Round-robin search
	// ==================================================

	// Walk the threads starting at the pointer and wrapping around
	// The first pending one wins
	always_comb begin
		int unsigned slot;
		grant_found = 1'b0;
		push_tid = rr_ptr;
		for (int i = 0; i < `PHX_NTHREADS; i++) begin
			slot = (int'(rr_ptr) + i) % `PHX_NTHREADS;
			if (!grant_found && pending[slot]) begin
				grant_found = 1'b1;
				push_tid = tid_t'(slot);
			end
		end
	end

	// A grant needs both a pending thread and a free FIFO entry
	always_comb begin
		if (grant_found && (credits != '0)) begin
			grant_state = granting;
		end else begin
			grant_state = idle;
		end
	end

	assign push = (grant_state == granting);
	assign grant_mask = push ? (tmask_t'(1) << push_tid) : '0;

	// ==================================================
	// Pending bits, pointer and credits
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			rr_ptr  <= '0;
			credits <= credit_t'(`PHX_TQ_CAP);
		end else begin
			// Clear the granted bit first so a new wake for the same thread survives
			pending <= (pending & ~grant_mask) | wake;

			// The thread after the winner gets top priority next
			if (push) begin
				if (push_tid == tid_t'(`PHX_NTHREADS - 1)) begin
					rr_ptr <= '0;
				end else begin
					rr_ptr <= push_tid + 1'b1;
				end
			end

			// A push and a return in the same cycle cancel out
			case ({push, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Returned credits come from pops of earlier pushes, so the count never passes capacity
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		(credit_ret && !push) |-> (credits < credit_t'(`PHX_TQ_CAP)))
		else $error("wake_arbiter: credit returned above capacity");

endmodule

/* test/thread_queue_tb.sv */
`timescale 1ns/1ns
`include "phx_settings.svh"

module thread_queue_tb;
	import phx_pkg::*;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 4;
	localparam int NUM_DIRECTED = 5;
	localparam int NUM_ENTRIES = 13;
	localparam int CYCLES_PER_ENTRY = 50;
	localparam int WATCHDOG_NS =
		(NUM_ENTRIES * CYCLES_PER_ENTRY + RESET_CYCLES + IDLE_CYCLES) * PERIOD;

	logic clk;
	logic rst;
	tmask_t wake;
	logic issue_req;
	logic issue_valid;
	tid_t issue_tid;
	tq_cnt_t tq_count;

	// Stimulus table, one row per test
	string names [NUM_ENTRIES];
	tmask_t masks [NUM_ENTRIES];
	int holds [NUM_ENTRIES];
	// Expected tq_count after the hold-off, or -1 to take it from the model
	int exp_cnt [NUM_ENTRIES];
	// Re-wake the threads that are stuck pending during the hold-off
	bit reps [NUM_ENTRIES];

	// Reference model state
	tmask_t m_pending;
	int m_ptr;
	int m_credits;
	tid_t m_fifo [$];
	tid_t exp_q [$];

	string cur_name;
	int value_errors;
	int missing_errors;
	int extra_errors;

	thread_queue_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.wake        (wake),
		.issue_req   (issue_req),
		.issue_valid (issue_valid),
		.issue_tid   (issue_tid),
		.tq_count    (tq_count)
	);

	always #(PERIOD / 2) clk = ~clk;

	// ==================================================
	// Reference model of the ready queue
	// ==================================================

	// Works on the inputs seen at each rising edge, which were set on the falling edge before
	always @(posedge clk) begin : ref_model
		int gid;
		if (rst) begin
			m_pending = '0;
			m_ptr = 0;
			m_credits = `PHX_TQ_CAP;
			m_fifo.delete();
			exp_q.delete();
		end else begin
			gid = -1;
			// Round-robin search from the pointer, only with a credit in hand
			if (m_credits > 0) begin
				for (int i = 0; i < `PHX_NTHREADS; i++) begin
					if (gid < 0 && m_pending[(m_ptr + i) % `PHX_NTHREADS]) begin
						gid = (m_ptr + i) % `PHX_NTHREADS;
					end
				end
			end
			// The pop sees the queue as it was before this edge's push
			if (issue_req && m_fifo.size() > 0) begin
				exp_q.push_back(m_fifo.pop_front());
				m_credits++;
			end
			if (gid >= 0) begin
				m_fifo.push_back(tid_t'(gid));
				m_pending[gid] = 1'b0;
				m_ptr = (gid + 1) % `PHX_NTHREADS;
				m_credits--;
			end
			// A wake in the grant cycle leaves the bit set again
			m_pending = m_pending | wake;
		end
	end

	// Compares one issue against the head of the expected list
	task automatic check_issue();
		tid_t exp_tid;
		if (issue_valid) begin
			assert (exp_q.size() != 0) else begin
				extra_errors++;
				$display("Unexpected issue of thread %0d in test %s", issue_tid, cur_name);
			end
			if (exp_q.size() != 0) begin
				exp_tid = exp_q.pop_front();
				assert (issue_tid == exp_tid) else begin
					value_errors++;
					$display("CHECK FAILED %s: expected %0d, actual %0d",
						cur_name, exp_tid, issue_tid);
				end
			end
		end
	endtask

	// Outputs are stable at the falling edge, and new inputs go out right after
	task automatic tick();
		@(negedge clk);
		check_issue();
	endtask

	task automatic fill_table();
		names[0] = "single_t5";
		masks[0] = 8'h20;
		holds[0] = 4;
		exp_cnt[0] = 1;
		names[1] = "multi_rr";
		masks[1] = 8'ha5;
		holds[1] = 6;
		exp_cnt[1] = 4;
		names[2] = "backpressure_all";
		masks[2] = 8'hff;
		holds[2] = 12;
		exp_cnt[2] = `PHX_TQ_CAP;
		names[3] = "coalesce";
		masks[3] = 8'hff;
		holds[3] = 14;
		exp_cnt[3] = `PHX_TQ_CAP;
		reps[3] = 1'b1;
		names[4] = "pair_wrap";
		masks[4] = 8'h81;
		holds[4] = 3;
		exp_cnt[4] = 2;
		for (int k = NUM_DIRECTED; k < NUM_ENTRIES; k++) begin
			names[k] = $sformatf("random_%0d", k - NUM_DIRECTED);
			masks[k] = tmask_t'($urandom);
			holds[k] = 1 + ($urandom % 12);
			exp_cnt[k] = -1;
		end
	endtask

	// ==================================================
	// Watchdog
	// ==================================================

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished (%0d value errors)", value_errors);
		$display("=== FAIL ===");
		$finish;
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int exp_count;
		int guard;
		clk = 1'b0;
		rst = 1'b1;
		wake = '0;
		issue_req = 1'b0;
		value_errors = 0;
		missing_errors = 0;
		extra_errors = 0;
		void'($urandom(32'h9567));
		fill_table();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Nothing may come out of the queue before any thread wakes
		cur_name = "reset_idle";
		for (int c = 0; c < IDLE_CYCLES; c++) begin
			tick();
			assert (!issue_valid) else begin
				value_errors++;
				$display("CHECK FAILED %s: expected %0d, actual %0d", cur_name, 0, issue_valid);
			end
			assert (tq_count == '0) else begin
				value_errors++;
				$display("CHECK FAILED %s: expected %0d, actual %0d", cur_name, 0, tq_count);
			end
		end

		for (int k = 0; k < NUM_ENTRIES; k++) begin
			cur_name = names[k];
			tick();
			wake = masks[k];
			issue_req = 1'b0;
			for (int h = 0; h < holds[k]; h++) begin
				tick();
				// Only threads blocked by missing credits get woken again
				if (reps[k] && m_credits == 0) begin
					wake = m_pending;
				end else begin
					wake = '0;
				end
			end
			wake = '0;
			exp_count = (exp_cnt[k] >= 0) ? exp_cnt[k] : m_fifo.size();
			assert (int'(tq_count) == exp_count) else begin
				value_errors++;
				$display("CHECK FAILED %s: expected %0d, actual %0d", cur_name, exp_count, tq_count);
			end

			// Drain until the model has nothing left to issue
			issue_req = 1'b1;
			guard = 0;
			while ((m_pending != '0 || m_fifo.size() != 0 || exp_q.size() != 0) && guard < 40) begin
				tick();
				guard++;
			end
			issue_req = 1'b0;
			tick();
			tick();
			assert (exp_q.size() == 0) else begin
				missing_errors += exp_q.size();
				$display("Test %s ended with %0d issues that never came", cur_name, exp_q.size());
				exp_q.delete();
			end
			assert (tq_count == '0) else begin
				value_errors++;
				$display("CHECK FAILED %s: expected %0d, actual %0d", cur_name, 0, tq_count);
			end
		end

		$display("Summary: %0d value errors, %0d missing issues, %0d extra issues",
			value_errors, missing_errors, extra_errors);
		if (value_errors + missing_errors + extra_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* thread_queue.f */
+incdir+src
src/phx_pkg.sv
src/thread_fifo.sv
src/wake_arbiter.sv
src/issue_stage.sv
src/thread_queue_top.sv
test/thread_queue_tb.sv
